// ==== gem.f ====
gem_pkg.sv
gem_cluster_decode.sv
gem_parity_ram.sv
gem_rawhits_buffer.sv
gem_debug_capture_ctrl.sv
gem.sv
tb_gem_chk.sv
tb_gem.sv

// ==== Bender.yml ====
package:
  name: gem

sources:
  - gem_pkg.sv
  - gem_cluster_decode.sv
  - gem_parity_ram.sv
  - gem_rawhits_buffer.sv
  - gem_debug_capture_ctrl.sv
  - gem.sv
  - target: test
    files:
      - tb_gem_chk.sv
      - tb_gem.sv

// ==== tb_gem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gem;

  import gem_pkg::*;

  localparam int          RAW_DEPTH       = 2048;          // dut defaults
  localparam int          DEBUG_DEPTH     = 1024;
  localparam int          RAW_ADDR_BITS   = $clog2(RAW_DEPTH);
  localparam int          DEBUG_ADDR_BITS = $clog2(DEBUG_DEPTH);
  localparam int          WATCHDOG_CYCLES = 50000;         // about 4x the 13k cycle test run
  localparam logic [31:0] SEED            = 32'hb469_2a48;

  logic                       clock = 1'b0;
  logic                       reset;
  frame_t                     gem_frame;
  logic                       fifo_wen;
  logic [RAW_ADDR_BITS-1:0]   fifo_wadr;
  logic [RAW_ADDR_BITS-1:0]   fifo_radr;
  cluster_sel_t               fifo_sel;
  logic [DEBUG_ADDR_BITS-1:0] debug_fifo_radr;
  cluster_sel_t               debug_fifo_sel;
  logic                       debug_fifo_reset;
  cluster_t                   fifo_rdata;
  cluster_t                   debug_fifo_rdata;
  logic [N_CLUSTERS-1:0]      parity_err_gem;
  logic [N_CLUSTERS-1:0]      debug_parity_err;
  logic                       debug_capture_full;
  cluster_t                   dut_cluster [N_CLUSTERS];  // numbered outputs as array
  logic [N_CLUSTERS-1:0]      dut_vpf;
  logic                       gem_nonzero;

  logic                       raw_chk;                   // read issued this cycle
  logic                       dbg_chk;

  // model state, updated at each rising edge
  logic                       started = 1'b0;
  logic                       s_reset = 1'b1;            // reset seen at last edge
  frame_t                     s_frame;                   // frame seen at last edge
  logic                       s_raw_chk;
  logic [RAW_ADDR_BITS-1:0]   s_radr;
  cluster_sel_t               s_sel;
  logic                       s_dbg_chk;
  logic [DEBUG_ADDR_BITS-1:0] s_dadr;
  cluster_sel_t               s_dsel;
  frame_t                     cur_frame;                 // clusters shown this cycle
  logic                       cur_valid;
  capture_state_t             m_state = CAPTURE_IDLE;
  frame_t                     raw_model [RAW_DEPTH];     // raw hits scoreboard
  frame_t                     capture_q [$];             // one entry per capture cycle

  always #4 clock = ~clock;                              // 8 ns period

  gem u_dut (
    .clock              (clock),
    .reset              (reset),
    .gem_frame          (gem_frame),
    .fifo_wen           (fifo_wen),
    .fifo_wadr          (fifo_wadr),
    .fifo_radr          (fifo_radr),
    .fifo_sel           (fifo_sel),
    .fifo_rdata         (fifo_rdata),
    .parity_err_gem     (parity_err_gem),
    .debug_fifo_radr    (debug_fifo_radr),
    .debug_fifo_sel     (debug_fifo_sel),
    .debug_fifo_reset   (debug_fifo_reset),
    .debug_fifo_rdata   (debug_fifo_rdata),
    .debug_parity_err   (debug_parity_err),
    .debug_capture_full (debug_capture_full),
    .cluster0           (dut_cluster[0]),
    .cluster1           (dut_cluster[1]),
    .cluster2           (dut_cluster[2]),
    .cluster3           (dut_cluster[3]),
    .vpf0               (dut_vpf[0]),
    .vpf1               (dut_vpf[1]),
    .vpf2               (dut_vpf[2]),
    .vpf3               (dut_vpf[3]),
    .gem_nonzero        (gem_nonzero)
  );

  // --------------------------------------------------
  // reference functions
  // --------------------------------------------------

  function automatic cluster_t ref_cluster(frame_t f, int i);
    return f[i*CLUSTER_BITS +: CLUSTER_BITS];            // cluster 0 in low bits
  endfunction

  function automatic logic ref_valid(frame_t f, int i);
    logic [ADR_BITS-1:0] adr;
    adr = f[i*CLUSTER_BITS +: ADR_BITS];
    return !(adr[ADR_BITS-1] && adr[ADR_BITS-2]);        // both top bits set = empty
  endfunction

  function automatic logic ref_nonzero(frame_t f);
    return |f;
  endfunction

  function automatic cluster_t ref_readback(frame_t stored, cluster_sel_t sel);
    return ref_cluster(stored, int'(sel));               // parity bits never seen
  endfunction

  function automatic frame_t rand_frame();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[FRAME_BITS-1:0];
  endfunction

  function automatic frame_t invalid_frame();
    frame_t f;
    f = rand_frame();
    for (int i = 0; i < N_CLUSTERS; i++) begin
      f[i*CLUSTER_BITS + ADR_BITS-1] = 1'b1;             // force empty slot
      f[i*CLUSTER_BITS + ADR_BITS-2] = 1'b1;
    end
    return f;
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------

  task automatic compare_cluster(input cluster_t got, input cluster_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first error");
    end
  endtask

  // --------------------------------------------------
  // model, sampled at the edge the dut samples
  // --------------------------------------------------

  always @(posedge clock) begin
    cur_frame = s_reset ? '0 : s_frame;                  // what the cluster outputs hold
    cur_valid = 1'b0;
    for (int i = 0; i < N_CLUSTERS; i++) begin
      if (!s_reset && ref_valid(s_frame, i)) cur_valid = 1'b1;
    end
    if (fifo_wen) raw_model[fifo_wadr] = cur_frame;
    if (reset) begin
      m_state = CAPTURE_IDLE;
    end else begin
      case (m_state)
        CAPTURE_IDLE: begin
          if (cur_valid) begin
            m_state = CAPTURE_WRITING;
            capture_q.delete();                          // new capture overwrites old
          end
        end
        CAPTURE_WRITING: begin
          capture_q.push_back(cur_frame);                // address = queue index
          if (capture_q.size() == DEBUG_DEPTH) m_state = CAPTURE_READOUT;
        end
        default: if (debug_fifo_reset) m_state = CAPTURE_IDLE;
      endcase
    end
    s_reset   = reset;
    s_frame   = gem_frame;
    s_raw_chk = raw_chk;
    s_radr    = fifo_radr;
    s_sel     = fifo_sel;
    s_dbg_chk = dbg_chk;
    s_dadr    = debug_fifo_radr;
    s_dsel    = debug_fifo_sel;
    started   = 1'b1;
  end

  // compare in mid cycle, outputs stable
  always @(negedge clock) begin
    if (started) begin
      if (u_dut.u_capture.u_chk.failed) begin
        $display("Capture controller assertion failed at %0t ns", $time);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
      end
      for (int i = 0; i < N_CLUSTERS; i++) begin
        compare_cluster(dut_cluster[i], s_reset ? '0 : ref_cluster(s_frame, i),
                        $sformatf("cluster%0d", i));
        compare_flag(dut_vpf[i], !s_reset && ref_valid(s_frame, i), $sformatf("vpf%0d", i));
      end
      compare_flag(gem_nonzero, !s_reset && ref_nonzero(s_frame), "gem_nonzero");
      compare_flag(debug_capture_full, m_state == CAPTURE_READOUT, "debug_capture_full");
      if (s_raw_chk) begin
        compare_cluster(fifo_rdata, ref_readback(raw_model[s_radr], s_sel), "fifo_rdata");
        compare_flag(|parity_err_gem, 1'b0, "parity_err_gem");
      end
      if (s_dbg_chk) begin
        compare_cluster(debug_fifo_rdata, ref_readback(capture_q[s_dadr], s_dsel),
                        "debug_fifo_rdata");
        compare_flag(|debug_parity_err, 1'b0, "debug_parity_err");
      end
    end
  end

  // --------------------------------------------------
  // stimulus tasks
  // --------------------------------------------------

  task automatic drive_frames(input int n, input logic valid_ok);
    for (int k = 0; k < n; k++) begin
      @(posedge clock);
      if (!valid_ok)   gem_frame <= invalid_frame();
      else if (k % 8 == 3) gem_frame <= '0;              // zero frame, valid and not nonzero
      else             gem_frame <= rand_frame();
    end
  endtask

  task automatic wait_capture_full(input int limit);
    int n;
    n = 0;
    while (debug_capture_full !== 1'b1 && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (debug_capture_full !== 1'b1) begin
      $display("Timed out after %0d cycles waiting for debug capture to fill", limit);
      $display("Test failures found");
      $fatal(1, "capture never completed");
    end
  endtask

  task automatic raw_hits_test();
    logic [RAW_ADDR_BITS-1:0] a;
    logic [RAW_ADDR_BITS-1:0] wadr_q [$];
    for (int k = 0; k < 256; k++) begin
      a = RAW_ADDR_BITS'($urandom_range(RAW_DEPTH-1, 0));
      wadr_q.push_back(a);
      @(posedge clock);
      gem_frame <= rand_frame();
      fifo_wen  <= 1'b1;
      fifo_wadr <= a;
    end
    @(posedge clock);
    fifo_wen <= 1'b0;
    foreach (wadr_q[k]) begin
      for (int s = 0; s < N_CLUSTERS; s++) begin
        @(posedge clock);
        fifo_radr <= wadr_q[k];
        fifo_sel  <= cluster_sel_t'(s);
        raw_chk   <= 1'b1;
      end
    end
    @(posedge clock);
    raw_chk <= 1'b0;
  endtask

  task automatic debug_readout();
    for (int a = 0; a < DEBUG_DEPTH; a++) begin
      for (int s = 0; s < N_CLUSTERS; s++) begin
        @(posedge clock);
        debug_fifo_radr <= DEBUG_ADDR_BITS'(a);
        debug_fifo_sel  <= cluster_sel_t'(s);
        dbg_chk         <= 1'b1;
      end
    end
    @(posedge clock);
    dbg_chk <= 1'b0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(SEED));
    reset            = 1'b1;
    gem_frame        = invalid_frame();                  // no capture while idle
    fifo_wen         = 1'b0;
    fifo_wadr        = '0;
    fifo_radr        = '0;
    fifo_sel         = '0;
    debug_fifo_radr  = '0;
    debug_fifo_sel   = '0;
    debug_fifo_reset = 1'b0;
    raw_chk          = 1'b0;
    dbg_chk          = 1'b0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare_flag(|dut_vpf, 1'b0, "vpf after reset");
    compare_flag(gem_nonzero, 1'b0, "gem_nonzero after reset");
    compare_flag(debug_capture_full, 1'b0, "debug_capture_full after reset");
    drive_frames(200, 1'b0);                             // empty clusters only
    @(negedge clock);
    compare_flag(debug_capture_full, 1'b0, "debug_capture_full on empty frames");
    drive_frames(DEBUG_DEPTH + 80, 1'b1);                // decode check and first capture
    wait_capture_full(DEBUG_DEPTH + 16);
    raw_hits_test();
    debug_readout();
    @(posedge clock);
    debug_fifo_reset <= 1'b1;                            // re-arm
    @(posedge clock);
    debug_fifo_reset <= 1'b0;
    @(negedge clock);
    compare_flag(debug_capture_full, 1'b0, "debug_capture_full after re-arm");
    drive_frames(DEBUG_DEPTH + 40, 1'b1);
    wait_capture_full(DEBUG_DEPTH + 16);
    debug_readout();
    repeat (2) @(posedge clock);                         // last read still in flight
    if (u_dut.u_capture.u_chk.failed) begin
      $display("Capture controller assertion failed");
      $display("Test failures found");
      $fatal(1, "assertion failure");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout reached after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule : tb_gem

`default_nettype wire

// ==== tb_gem_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gem_chk #(
  parameter int DEPTH = 1024                        // debug store depth
) (
  input logic                       clock,
  input logic                       reset,
  input gem_pkg::capture_state_t    state,           // fsm state of the controller
  input logic                       write_enable,
  input logic [$clog2(DEPTH)-1:0]   write_addr,
  input logic                       capture_full
);

  import gem_pkg::*;

  logic failed = 1'b0;                               // set by any assertion failure

  // --------------------------------------------------
  // capture fsm properties
  // --------------------------------------------------

  a_wen_counts_up: assert property (@(posedge clock) disable iff (reset)
    write_enable && $past(write_enable) |-> write_addr == $past(write_addr) + 1'b1)
    else begin
      $error("debug write address not consecutive while writing");
      failed = 1'b1;
    end

  a_addr_zero_idle: assert property (@(posedge clock) disable iff (reset)
    state == CAPTURE_IDLE |-> write_addr == '0)      // counter parked while armed
    else begin
      $error("debug write address not zero in CAPTURE_IDLE");
      failed = 1'b1;
    end

  a_full_after_last: assert property (@(posedge clock) disable iff (reset)
    $rose(capture_full) |-> $past(write_enable) && $past(write_addr) == DEPTH - 1)
    else begin
      $error("capture_full rose without a write to the last address");
      failed = 1'b1;
    end

endmodule : tb_gem_chk

bind gem_debug_capture_ctrl tb_gem_chk #(.DEPTH(DEPTH)) u_chk (
  .clock        (clock),
  .reset        (reset),
  .state        (state),
  .write_enable (write_enable),
  .write_addr   (write_addr),
  .capture_full (capture_full)
);

`default_nettype wire

// ==== gem.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem #(
  parameter int RAW_DEPTH   = 2048,                                // raw hits bx depth
  parameter int DEBUG_DEPTH = 1024                                 // debug capture depth
) (
  input  logic                             clock,                  // 40 MHz system clock
  input  logic                             reset,                  // sync, active high

  input  gem_pkg::frame_t                  gem_frame,              // 56 bit trigger frame

  // raw hits store
  input  logic                             fifo_wen,               // 1=write clusters
  input  logic [$clog2(RAW_DEPTH)-1:0]     fifo_wadr,              // write bx address
  input  logic [$clog2(RAW_DEPTH)-1:0]     fifo_radr,              // read bx address
  input  gem_pkg::cluster_sel_t            fifo_sel,               // read cluster 0-3
  output gem_pkg::cluster_t                fifo_rdata,             // read data
  output logic [gem_pkg::N_CLUSTERS-1:0]   parity_err_gem,         // per store parity

  // debug capture store
  input  logic [$clog2(DEBUG_DEPTH)-1:0]   debug_fifo_radr,        // read bx address
  input  gem_pkg::cluster_sel_t            debug_fifo_sel,         // read cluster 0-3
  input  logic                             debug_fifo_reset,       // re-arm capture
  output gem_pkg::cluster_t                debug_fifo_rdata,       // read data
  output logic [gem_pkg::N_CLUSTERS-1:0]   debug_parity_err,       // per store parity
  output logic                             debug_capture_full,     // capture done

  // decoded clusters
  output gem_pkg::cluster_t                cluster0,               // {size, pad address}
  output gem_pkg::cluster_t                cluster1,
  output gem_pkg::cluster_t                cluster2,
  output gem_pkg::cluster_t                cluster3,
  output logic                             vpf0,                   // cluster0 valid
  output logic                             vpf1,
  output logic                             vpf2,
  output logic                             vpf3,
  output logic                             gem_nonzero             // frame had any bit set
);

  import gem_pkg::*;

  localparam int DEBUG_ADDR_BITS = $clog2(DEBUG_DEPTH);

  cluster_t                   cluster [N_CLUSTERS];  // decoded clusters, one bx late
  logic [N_CLUSTERS-1:0]      vpf;                   // valid flags
  logic                       any_valid;             // capture trigger
  logic                       debug_wen;             // from capture fsm
  logic [DEBUG_ADDR_BITS-1:0] debug_wadr;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------

  gem_cluster_decode u_decode (
    .clock     (clock),
    .reset     (reset),
    .frame     (gem_frame),
    .cluster   (cluster),
    .vpf       (vpf),
    .any_valid (any_valid),
    .nonzero   (gem_nonzero)
  );

  assign cluster0 = cluster[0];
  assign cluster1 = cluster[1];
  assign cluster2 = cluster[2];
  assign cluster3 = cluster[3];

  assign vpf0 = vpf[0];
  assign vpf1 = vpf[1];
  assign vpf2 = vpf[2];
  assign vpf3 = vpf[3];

  // --------------------------------------------------
  // raw hits store, caller addressed
  // --------------------------------------------------

  gem_rawhits_buffer #(
    .DEPTH        (RAW_DEPTH)
  ) u_raw (
    .clock        (clock),
    .write_enable (fifo_wen),
    .write_addr   (fifo_wadr),
    .write_data   (cluster),                         // clusters on the outputs now
    .read_addr    (fifo_radr),
    .read_sel     (fifo_sel),
    .read_data    (fifo_rdata),
    .parity_err   (parity_err_gem)
  );

  // --------------------------------------------------
  // debug capture
  // --------------------------------------------------

  gem_debug_capture_ctrl #(
    .DEPTH         (DEBUG_DEPTH)
  ) u_capture (
    .clock         (clock),
    .reset         (reset),
    .any_valid     (any_valid),
    .capture_reset (debug_fifo_reset),
    .write_enable  (debug_wen),
    .write_addr    (debug_wadr),
    .capture_full  (debug_capture_full)
  );

  gem_rawhits_buffer #(
    .DEPTH        (DEBUG_DEPTH)
  ) u_debug (
    .clock        (clock),
    .write_enable (debug_wen),
    .write_addr   (debug_wadr),                      // fsm owned address
    .write_data   (cluster),
    .read_addr    (debug_fifo_radr),
    .read_sel     (debug_fifo_sel),
    .read_data    (debug_fifo_rdata),
    .parity_err   (debug_parity_err)
  );

endmodule : gem

`default_nettype wire

// ==== gem_debug_capture_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem_debug_capture_ctrl #(
  parameter int DEPTH = 1024                        // debug store depth
) (
  input  logic                     clock,           // 40 MHz system clock
  input  logic                     reset,           // sync, active high
  input  logic                     any_valid,       // some vpf high this cycle
  input  logic                     capture_reset,   // re-arm level from readout
  output logic                     write_enable,    // debug store write strobe
  output logic [$clog2(DEPTH)-1:0] write_addr,      // debug store write address
  output logic                     capture_full     // store holds a full capture
);

  import gem_pkg::*;

  localparam int                   ADDR_BITS = $clog2(DEPTH);
  localparam logic [ADDR_BITS-1:0] LAST_ADDR = ADDR_BITS'(DEPTH - 1);

  capture_state_t state;                            // capture fsm
  capture_state_t state_next;
  logic           last_write;                       // writing the final entry

  assign last_write = (write_addr == LAST_ADDR);

  // --------------------------------------------------
  // capture fsm
  // --------------------------------------------------

  always_comb begin
    state_next = state;                             // hold by default
    case (state)
      CAPTURE_IDLE:    if (any_valid)     state_next = CAPTURE_WRITING;  // first hit
      CAPTURE_WRITING: if (last_write)    state_next = CAPTURE_READOUT;  // no way to stop
      CAPTURE_READOUT: if (capture_reset) state_next = CAPTURE_IDLE;     // re-arm
      default:                            state_next = CAPTURE_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= CAPTURE_IDLE;
      write_addr <= '0;
    end else begin
      state <= state_next;
      // count up while writing, park at zero otherwise
      if (state == CAPTURE_WRITING && !last_write) begin
        write_addr <= write_addr + 1'b1;
      end else begin
        write_addr <= '0;
      end
    end
  end

  assign write_enable = (state == CAPTURE_WRITING);  // one write per bx
  assign capture_full = (state == CAPTURE_READOUT);

endmodule : gem_debug_capture_ctrl

`default_nettype wire

// ==== gem_rawhits_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem_rawhits_buffer #(
  parameter int DEPTH = 2048                                        // bx depth of each store
) (
  input  logic                           clock,                     // 40 MHz system clock
  input  logic                           write_enable,              // write all four clusters
  input  logic [$clog2(DEPTH)-1:0]       write_addr,                // shared write address
  input  gem_pkg::cluster_t              write_data [gem_pkg::N_CLUSTERS],
  input  logic [$clog2(DEPTH)-1:0]       read_addr,                 // shared read address
  input  gem_pkg::cluster_sel_t          read_sel,                  // cluster to read out
  output gem_pkg::cluster_t              read_data,                 // selected cluster
  output logic [gem_pkg::N_CLUSTERS-1:0] parity_err                 // one bit per store
);

  import gem_pkg::*;

  localparam int ADDR_BITS = $clog2(DEPTH);

  cluster_t     ram_rdata [N_CLUSTERS];  // read port of each store
  cluster_sel_t sel_q;                   // select aligned with ram output

  // --------------------------------------------------
  // one store per cluster slot
  // --------------------------------------------------

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : g_ram
    gem_parity_ram #(
      .DEPTH        (DEPTH)
    ) u_ram (
      .clock        (clock),
      .write_enable (write_enable),
      .write_addr   (write_addr[ADDR_BITS-1:0]),
      .write_data   (write_data[i]),
      .read_addr    (read_addr[ADDR_BITS-1:0]),
      .read_data    (ram_rdata[i]),
      .parity_err   (parity_err[i])         // all four reported, not just selected
    );
  end

  // --------------------------------------------------
  // output multiplexer
  // --------------------------------------------------

  // select sampled on the same edge as the read address
  always_ff @(posedge clock) begin
    sel_q <= read_sel;
  end

  assign read_data = ram_rdata[sel_q];  // pick cluster 0-3

endmodule : gem_rawhits_buffer

`default_nettype wire

// ==== gem_parity_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem_parity_ram #(
  parameter int DEPTH = 2048                      // entries in the store
) (
  input  logic                     clock,         // 40 MHz system clock
  input  logic                     write_enable,  // write at this edge
  input  logic [$clog2(DEPTH)-1:0] write_addr,    // write bx address
  input  gem_pkg::cluster_t        write_data,    // cluster to store
  input  logic [$clog2(DEPTH)-1:0] read_addr,     // read bx address
  output gem_pkg::cluster_t        read_data,     // data one cycle after address
  output logic                     parity_err     // either half failed parity
);

  import gem_pkg::*;

  // each half is stored with its parity bit on top
  logic [HALF_BITS:0] mem_lo [DEPTH];             // cluster bits 6:0
  logic [HALF_BITS:0] mem_hi [DEPTH];             // cluster bits 13:7

  logic [HALF_BITS-1:0] wr_lo;                    // write half, low
  logic [HALF_BITS-1:0] wr_hi;                    // write half, high
  logic                 wr_par_lo;                // odd parity of low half
  logic                 wr_par_hi;                // odd parity of high half

  logic [HALF_BITS:0]   rd_lo;                    // read word, low half
  logic [HALF_BITS:0]   rd_hi;                    // read word, high half
  logic                 rd_par_lo;                // recomputed on read
  logic                 rd_par_hi;

  // --------------------------------------------------
  // write side
  // --------------------------------------------------

  assign wr_lo     = write_data[HALF_BITS-1:0];
  assign wr_hi     = write_data[CLUSTER_BITS-1:HALF_BITS];
  assign wr_par_lo = ~(^wr_lo);                   // odd parity, total ones odd
  assign wr_par_hi = ~(^wr_hi);

  always_ff @(posedge clock) begin
    if (write_enable) begin
      mem_lo[write_addr] <= {wr_par_lo, wr_lo};
      mem_hi[write_addr] <= {wr_par_hi, wr_hi};
    end
  end

  // --------------------------------------------------
  // read side
  // --------------------------------------------------

  // read first, same address write shows up next access
  always_ff @(posedge clock) begin
    rd_lo <= mem_lo[read_addr];
    rd_hi <= mem_hi[read_addr];
  end

  assign read_data = {rd_hi[HALF_BITS-1:0], rd_lo[HALF_BITS-1:0]};

  assign rd_par_lo = ~(^rd_lo[HALF_BITS-1:0]);    // expected parity of read half
  assign rd_par_hi = ~(^rd_hi[HALF_BITS-1:0]);

  // stored bit vs recomputed bit, per half
  assign parity_err = (rd_lo[HALF_BITS] != rd_par_lo) |
                      (rd_hi[HALF_BITS] != rd_par_hi);

endmodule : gem_parity_ram

`default_nettype wire

// ==== gem_cluster_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem_cluster_decode (
  input  logic                           clock,                         // 40 MHz system clock
  input  logic                           reset,                         // sync, active high
  input  gem_pkg::frame_t                frame,                         // new frame every bx
  output gem_pkg::cluster_t              cluster [gem_pkg::N_CLUSTERS], // registered clusters
  output logic [gem_pkg::N_CLUSTERS-1:0] vpf,                           // valid pad flags
  output logic                           any_valid,                     // any cluster valid
  output logic                           nonzero                        // any frame bit set
);

  import gem_pkg::*;

  logic [ADR_BITS-1:0]   adr [N_CLUSTERS];  // pad address of incoming cluster
  logic [CNT_BITS-1:0]   cnt [N_CLUSTERS];  // size of incoming cluster
  logic [N_CLUSTERS-1:0] vpf_d;             // valid flags before the register

  // --------------------------------------------------
  // split frame into address and size fields
  // --------------------------------------------------

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : g_split
    assign adr[i]   = frame[i*CLUSTER_BITS +: ADR_BITS];
    assign cnt[i]   = frame[i*CLUSTER_BITS+ADR_BITS +: CNT_BITS];
    // top two address bits both set marks an empty slot
    assign vpf_d[i] = ~(&adr[i][ADR_BITS-1 -: 2]);
  end

  // --------------------------------------------------
  // one cycle decode register
  // --------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < N_CLUSTERS; i++) begin
        cluster[i] <= '0;                   // clear cluster outputs
      end
      vpf     <= '0;                        // no valid flags in reset
      nonzero <= 1'b0;
    end else begin
      for (int i = 0; i < N_CLUSTERS; i++) begin
        cluster[i] <= {cnt[i], adr[i]};     // repack size over address
      end
      vpf     <= vpf_d;
      nonzero <= |frame;                    // or of all 56 bits
    end
  end

  assign any_valid = |vpf;                  // capture trigger level

endmodule : gem_cluster_decode

`default_nettype wire

// ==== gem_pkg.sv ====
`default_nettype none

package gem_pkg;

  // --------------------------------------------------
  // cluster field layout
  // --------------------------------------------------

  localparam int N_CLUSTERS   = 4;                       // clusters per 40 MHz frame
  localparam int ADR_BITS     = 11;                      // pad address, low bits
  localparam int CNT_BITS     = 3;                       // cluster size, top bits
  localparam int CLUSTER_BITS = ADR_BITS + CNT_BITS;     // 14 bit cluster word
  localparam int FRAME_BITS   = N_CLUSTERS * CLUSTER_BITS; // 56 bit frame
  localparam int HALF_BITS    = CLUSTER_BITS / 2;        // parity protected half

  // --------------------------------------------------
  // data types
  // --------------------------------------------------

  typedef logic [CLUSTER_BITS-1:0] cluster_t;            // one cluster {cnt, adr}

  // cluster 0 sits in the lowest bits
  typedef logic [FRAME_BITS-1:0] frame_t;

  typedef logic [$clog2(N_CLUSTERS)-1:0] cluster_sel_t;  // picks one of four

  // --------------------------------------------------
  // debug capture states
  // --------------------------------------------------

  typedef enum logic [1:0] {
    CAPTURE_IDLE    = 2'd0,                              // armed, waiting for hits
    CAPTURE_WRITING = 2'd1,                              // filling the debug store
    CAPTURE_READOUT = 2'd2                               // full, held for readout
  } capture_state_t;

endpackage : gem_pkg

`default_nettype wire
